// ==== Bender.yml ====
package:
  name: ext_bus_sys

export_include_dirs:
  - common

sources:
  - common/xbus_pkg.sv
  - xbus/xbus_serializer.sv
  - xbus/xbus_arbiter.sv
  - verilog/apb_xbus_bridge.sv
  - verilog/block_copier.sv
  - verilog/ext_bus_sys.sv
  - target: test
    files:
      - tests/xbus_mem_model.sv
      - tests/xbus_properties.sv
      - tests/ext_bus_sys_tb.sv

// ==== all.f ====
+incdir+common
common/xbus_pkg.sv
xbus/xbus_serializer.sv
xbus/xbus_arbiter.sv
verilog/apb_xbus_bridge.sv
verilog/block_copier.sv
verilog/ext_bus_sys.sv
tests/xbus_mem_model.sv
tests/xbus_properties.sv
tests/ext_bus_sys_tb.sv

// ==== common/xbus_config.svh ====
// fixed widths of the byte-pin bus; the design supports 32-bit words only
// copier offsets are decoded from paddr[3:0]
`ifndef XBUS_CONFIG_SVH
`define XBUS_CONFIG_SVH

// external bus widths
`define XBUS_ADDR_W 32
`define XBUS_DATA_W 32
`define XBUS_PIN_W 8

// bytes per word, also cycles per address or data phase
`define XBUS_BYTES 4

// block copier register map
`define COPY_SRC_OFS 4'h0
`define COPY_DST_OFS 4'h4
`define COPY_CNT_OFS 4'h8
`define COPY_STAT_OFS 4'hC

`endif

// ==== common/xbus_pkg.sv ====
// shared types of the byte-pin bus subsystem
// word transfers only, no byte enables
`include "xbus_config.svh"

package xbus_pkg;

  // external byte address
  typedef logic [`XBUS_ADDR_W-1:0] addr_t;

  // one transfer word
  typedef logic [`XBUS_DATA_W-1:0] data_t;

  // one byte on a pin group
  typedef logic [`XBUS_PIN_W-1:0] pin_byte_t;

  // requester side of a transfer, held stable until done
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } xfer_req_t;

  // done is a single-cycle pulse, rdata valid with it
  typedef struct packed {
    logic  done;
    data_t rdata;
  } xfer_rsp_t;

  // serializer phases, ADDR and DATA last four cycles each
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } xbus_phase_e;

endpackage

// ==== tests/ext_bus_sys_tb.sv ====
// testbench for ext_bus_sys with a byte-pin memory model on the pins
// port 0 words, copy sources and copy destinations stay in separate regions
`timescale 1ns/100ps
`include "xbus_config.svh"

module ext_bus_sys_tb import xbus_pkg::*; ();

  localparam int TIMEOUT = 200;              // cycles per APB access
  localparam logic [31:0] POLY = 32'h80200003;

  logic      clk;
  logic      rst_n;
  logic      p0_psel, p0_penable, p0_pwrite;
  addr_t     p0_paddr;
  data_t     p0_pwdata, p0_prdata;
  logic      p0_pready, p0_pslverr;
  logic      p1_psel, p1_penable, p1_pwrite;
  addr_t     p1_paddr;
  data_t     p1_pwdata, p1_prdata;
  logic      p1_pready;
  pin_byte_t xa, xd_out, xd_in;
  logic      xstb, xwe, xd_oe;

  logic [31:0] lfsr = 32'd2;
  data_t       shadow [256];
  bit          written [256];
  int          checks, errors, strobes, tests;

  ext_bus_sys ext_bus_sys_i (.*);
  xbus_mem_model mem_i (.*);

  bind ext_bus_sys xbus_properties props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .xstb     (xstb),
    .xwe      (xwe),
    .xd_oe    (xd_oe),
    .bus_done (bus_rsp.done),
    .done0    (br_rsp.done),
    .done1    (cp_rsp.done),
    .valid0   (br_req.valid),
    .valid1   (cp_req.valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // expected memory word from the write shadow or the power-up pattern
  function automatic data_t ref_word(input addr_t a);
    logic [7:0] idx;
    idx = a[9:2];
    if (written[idx]) return shadow[idx];
    return (32'(idx) * 32'h01010101) ^ 32'hA5A5A5A5;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ POLY) : (lfsr >> 1);
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic abort(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic idle_bus();
    {p0_psel, p0_penable, p0_pwrite, p0_paddr, p0_pwdata} = '0;
    {p1_psel, p1_penable, p1_pwrite, p1_paddr, p1_pwdata} = '0;
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // every completed port 0 read is compared with the reference
  always @(posedge clk) begin
    if (xstb) strobes++;
    if (p0_psel && p0_penable && p0_pready && !p0_pwrite && !p0_pslverr) begin
      check($sformatf("p0_prdata[%h]", p0_paddr), p0_prdata, ref_word(p0_paddr));
    end
  end

  task automatic apb_access(input bit port, input bit wr, input addr_t a, input data_t wd,
                            output data_t rd, output logic err);
    int   n;
    logic rdy;
    @(negedge clk);
    if (port) begin
      {p1_psel, p1_pwrite, p1_paddr, p1_pwdata} = {1'b1, wr, a, wd};
    end else begin
      {p0_psel, p0_pwrite, p0_paddr, p0_pwdata} = {1'b1, wr, a, wd};
    end
    @(negedge clk);
    p0_penable = !port;
    p1_penable = port;
    n   = 0;
    rdy = 1'b0;
    while (!rdy && n < TIMEOUT) begin
      @(posedge clk);
      rdy = port ? p1_pready : p0_pready;
      n++;
    end
    if (!rdy) begin
      abort($sformatf("no pready on port %0d within %0d cycles", port, TIMEOUT));
    end else begin
      rd  = port ? p1_prdata : p0_prdata;
      err = port ? 1'b0 : p0_pslverr;
      if (!port && wr && !err) begin
        shadow[a[9:2]]  = wd;
        written[a[9:2]] = 1'b1;
      end
      @(negedge clk);
      idle_bus();
    end
  endtask

  // program one copy and wait for it with optional port 0 traffic in words 128..159
  task automatic run_copy(input int src_w, input int dst_w, input int cnt, input bit traffic);
    data_t       rd;
    logic        err;
    logic [31:0] r, wd;
    int          i;
    apb_access(1, 1, `COPY_SRC_OFS, src_w * 4, rd, err);
    apb_access(1, 1, `COPY_DST_OFS, dst_w * 4, rd, err);
    for (i = 0; i < cnt; i++) begin
      shadow[dst_w + i]  = ref_word((src_w + i) * 4);
      written[dst_w + i] = 1'b1;
    end
    apb_access(1, 1, `COPY_CNT_OFS, cnt, rd, err);
    for (i = 0; traffic && i < 12; i++) begin
      rand_bits(6, r);  // bit 5 write, bits 4:0 word
      rand_bits(32, wd);
      apb_access(0, r[5], (128 + r[4:0]) * 4, wd, rd, err);
    end
    i  = 0;
    rd = 32'h1;
    while (rd[0] && i < 500) begin
      apb_access(1, 0, `COPY_STAT_OFS, '0, rd, err);
      i++;
    end
    if (rd[0]) begin
      abort("copy still busy after 500 status reads");
    end else begin
      check("copy status", rd, 32'h0);
      for (i = 0; i < cnt; i++) begin
        apb_access(0, 0, (dst_w + i) * 4, '0, rd, err);
      end
    end
  endtask

  initial begin
    int          err0, base;
    data_t       rd;
    logic        err;
    logic [31:0] r, wd;
    rst_n = 1'b0;
    idle_bus();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    err0 = errors;
    @(negedge clk);
    check("xstb", xstb, 0);
    check("xwe", xwe, 0);
    check("xd_oe", xd_oe, 0);
    check("xa", xa, 0);
    check("xd_out", xd_out, 0);
    check("p0_pready", p0_pready, 0);
    check("p1_pready", p1_pready, 0);
    apb_access(1, 0, `COPY_STAT_OFS, '0, rd, err);
    check("copy status", rd, 0);
    report("reset", err0);

    err0 = errors;
    repeat (8) begin
      rand_bits(6, r);
      apb_access(0, 0, {r[5:0], 2'b00}, '0, rd, err);
    end
    repeat (8) begin
      rand_bits(6, r);
      rand_bits(32, wd);
      apb_access(0, 1, {r[5:0], 2'b00}, wd, rd, err);
      apb_access(0, 0, {r[5:0], 2'b00}, '0, rd, err);
    end
    report("port 0 read/write", err0);

    err0 = errors;
    base = strobes;
    apb_access(0, 0, 32'h0000_0011, '0, rd, err);
    check("p0_pslverr", err, 1);
    apb_access(0, 1, 32'h0000_0022, 32'h1234_5678, rd, err);
    check("p0_pslverr", err, 1);
    check("xstb count", strobes, base);
    report("unaligned", err0);

    err0 = errors;
    rand_bits(3, r);
    run_copy(64, 96, r[2:0] + 1, 0);
    report("copy", err0);

    err0 = errors;
    run_copy(192, 224, 8, 1);
    report("copy with traffic", err0);

    err0 = errors;
    apb_access(1, 0, `COPY_SRC_OFS, '0, rd, err);
    check("copy src", rd, (192 + 8) * 4);
    apb_access(1, 0, `COPY_DST_OFS, '0, rd, err);
    check("copy dst", rd, (224 + 8) * 4);
    report("copy registers", err0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/xbus_mem_model.sv ====
// byte-pin memory of 256 words with fixed timing, no wait states
// word index is addr[9:2], higher address bits are ignored
`timescale 1ns/100ps

module xbus_mem_model import xbus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  pin_byte_t xa,
  input  logic      xstb,
  input  logic      xwe,
  input  pin_byte_t xd_out,
  input  logic      xd_oe,
  output pin_byte_t xd_in
);

  data_t       mem [256];
  addr_t       addr_q;
  logic        active;  // A1 to D3 of a transfer
  logic [2:0]  cyc;     // 1..3 address, 4..7 data
  logic        we_q;
  logic [23:0] wb_q;    // write bytes 0..2
  logic [7:0]  widx;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h01010101) ^ 32'hA5A5A5A5;
    end
  end

  assign widx  = addr_q[9:2];
  // read bytes come straight from the array during D cycles
  assign xd_in = (active && cyc[2] && !we_q) ? mem[widx][cyc[1:0]*8 +: 8] : '0;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      cyc    <= '0;
      we_q   <= 1'b0;
    end else if (xstb) begin
      addr_q[7:0] <= xa;  // A0
      we_q        <= xwe;
      active      <= 1'b1;
      cyc         <= 3'd1;
    end else if (active) begin
      if (!cyc[2]) begin
        addr_q[cyc[1:0]*8 +: 8] <= xa;
      end else if (xd_oe && cyc != 3'd7) begin
        wb_q[cyc[1:0]*8 +: 8] <= xd_out;
      end
      if (cyc == 3'd7) begin
        active <= 1'b0;
        if (we_q && xd_oe) begin
          mem[widx] <= {xd_out, wb_q};  // write lands at D3
        end
      end
      cyc <= cyc + 3'd1;
    end
  end

endmodule

// ==== tests/xbus_properties.sv ====
// pin protocol and grant checks bound into the top level
`timescale 1ns/100ps

module xbus_properties (
  input logic clk,
  input logic rst_n,
  input logic xstb,
  input logic xwe,
  input logic xd_oe,
  input logic bus_done,
  input logic done0,
  input logic done1,
  input logic valid0,
  input logic valid1
);

  // D0..D3 sit four to seven cycles after the A0 strobe
  a_oe_in_write_data: assert property (@(posedge clk) disable iff (!rst_n)
    xd_oe |-> xwe && ($past(xstb, 4) || $past(xstb, 5) || $past(xstb, 6) || $past(xstb, 7)))
    else $error("xd_oe high outside the data phase of a write");

  a_strobe_gap: assert property (@(posedge clk) disable iff (!rst_n)
    xstb |=> !xstb [*7])
    else $error("xstb again within seven cycles of a strobe");

  // a bus done goes to exactly one requester that still holds valid
  a_done_routing: assert property (@(posedge clk) disable iff (!rst_n)
    bus_done |-> (done0 ^ done1) && (done0 ? valid0 : valid1))
    else $error("bus done not routed to exactly one waiting requester");

endmodule

// ==== verilog/apb_xbus_bridge.sv ====
// APB slave, one external word transfer per aligned access
// unaligned access ends in its first cycle with pslverr and no transfer
`timescale 1ns/100ps

module apb_xbus_bridge import xbus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  addr_t     paddr,
  input  data_t     pwdata,
  output data_t     prdata,
  output logic      pready,
  output logic      pslverr,
  output xfer_req_t req,
  input  xfer_rsp_t rsp
);

  logic access;
  logic aligned;
  logic valid_q;  // request outstanding

  assign access  = psel && penable;
  assign aligned = (paddr[1:0] == 2'b00);

  // raised after the first access cycle, cleared by done
  // master leaves the access phase with pready, so no second request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (rsp.done) begin
      valid_q <= 1'b0;
    end else if (access && aligned) begin
      valid_q <= 1'b1;
    end
  end

  // APB holds address and data for the whole access phase
  assign req.valid = valid_q;
  assign req.write = pwrite;
  assign req.addr  = paddr;
  assign req.wdata = pwdata;

  assign pslverr = access && !aligned;
  assign pready  = rsp.done || pslverr;
  assign prdata  = rsp.rdata;  // taken by the master in the done cycle

endmodule

// ==== verilog/block_copier.sv ====
// word copier, one read then one write per word, addresses step by 4
// register writes are ignored while a copy runs
`timescale 1ns/100ps
`include "xbus_config.svh"

module block_copier import xbus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  addr_t     paddr,
  input  data_t     pwdata,
  output data_t     prdata,
  output logic      pready,
  output xfer_req_t req,
  input  xfer_rsp_t rsp
);

  typedef enum logic [1:0] {
    CP_IDLE,
    CP_READ,
    CP_WRITE
  } cp_state_e;

  cp_state_e state;
  addr_t src_q;
  addr_t dst_q;
  data_t cnt_q;   // words left
  data_t buf_q;   // word in transit
  logic  busy;
  logic  wr_en;

  assign busy   = (state != CP_IDLE);
  assign pready = psel && penable;  // zero wait states
  assign wr_en  = pready && pwrite && !busy;

  // register readback
  always_comb begin
    case (paddr[3:0])
      `COPY_SRC_OFS:  prdata = src_q;
      `COPY_DST_OFS:  prdata = dst_q;
      `COPY_CNT_OFS:  prdata = cnt_q;
      `COPY_STAT_OFS: prdata = {cnt_q[`XBUS_DATA_W-2:0], busy};
      default:        prdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CP_IDLE;
      src_q <= '0;
      dst_q <= '0;
      cnt_q <= '0;
    end else begin
      case (state)
        CP_IDLE: begin
          if (wr_en) begin
            case (paddr[3:0])
              `COPY_SRC_OFS: src_q <= pwdata;
              `COPY_DST_OFS: dst_q <= pwdata;
              `COPY_CNT_OFS: begin
                cnt_q <= pwdata;
                if (pwdata != '0) begin
                  state <= CP_READ;  // nonzero count starts the copy
                end
              end
              default: ;
            endcase
          end
        end
        CP_READ: begin
          if (rsp.done) begin
            state <= CP_WRITE;
          end
        end
        CP_WRITE: begin
          if (rsp.done) begin
            src_q <= src_q + addr_t'(`XBUS_BYTES);
            dst_q <= dst_q + addr_t'(`XBUS_BYTES);
            cnt_q <= cnt_q - data_t'(1);
            state <= (cnt_q == data_t'(1)) ? CP_IDLE : CP_READ;
          end
        end
        default: state <= CP_IDLE;
      endcase
    end
  end

  // source word, valid from the read done until the write is issued
  always_ff @(posedge clk) begin
    if (state == CP_READ && rsp.done) begin
      buf_q <= rsp.rdata;
    end
  end

  // fields only change on a done edge
  assign req.valid = busy;
  assign req.write = (state == CP_WRITE);
  assign req.addr  = (state == CP_WRITE) ? dst_q : src_q;
  assign req.wdata = buf_q;

endmodule

// ==== verilog/ext_bus_sys.sv ====
// byte-pin external bus shared by the APB bridge (port 0) and the copier (port 1)
// bridge is requester 0 of the arbiter, copier requester 1
`timescale 1ns/100ps

module ext_bus_sys import xbus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // port 0, external memory window
  input  logic      p0_psel,
  input  logic      p0_penable,
  input  logic      p0_pwrite,
  input  addr_t     p0_paddr,
  input  data_t     p0_pwdata,
  output data_t     p0_prdata,
  output logic      p0_pready,
  output logic      p0_pslverr,
  // port 1, copier registers
  input  logic      p1_psel,
  input  logic      p1_penable,
  input  logic      p1_pwrite,
  input  addr_t     p1_paddr,
  input  data_t     p1_pwdata,
  output data_t     p1_prdata,
  output logic      p1_pready,
  // pins
  output pin_byte_t xa,
  output logic      xstb,
  output logic      xwe,
  output pin_byte_t xd_out,
  output logic      xd_oe,
  input  pin_byte_t xd_in
);

  xfer_req_t br_req;
  xfer_rsp_t br_rsp;
  xfer_req_t cp_req;
  xfer_rsp_t cp_rsp;
  xfer_req_t bus_req;
  xfer_rsp_t bus_rsp;

  apb_xbus_bridge bridge_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (p0_psel),
    .penable (p0_penable),
    .pwrite  (p0_pwrite),
    .paddr   (p0_paddr),
    .pwdata  (p0_pwdata),
    .prdata  (p0_prdata),
    .pready  (p0_pready),
    .pslverr (p0_pslverr),
    .req     (br_req),
    .rsp     (br_rsp)
  );

  block_copier copier_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (p1_psel),
    .penable (p1_penable),
    .pwrite  (p1_pwrite),
    .paddr   (p1_paddr),
    .pwdata  (p1_pwdata),
    .prdata  (p1_prdata),
    .pready  (p1_pready),
    .req     (cp_req),
    .rsp     (cp_rsp)
  );

  xbus_arbiter arbiter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req0    (br_req),
    .req1    (cp_req),
    .rsp0    (br_rsp),
    .rsp1    (cp_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  xbus_serializer serializer_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (bus_req),
    .rsp    (bus_rsp),
    .xa     (xa),
    .xstb   (xstb),
    .xwe    (xwe),
    .xd_out (xd_out),
    .xd_oe  (xd_oe),
    .xd_in  (xd_in)
  );

endmodule

// ==== xbus/xbus_arbiter.sv ====
// round-robin between exactly two requesters
// grant is combinational when unlocked, then held until the transfer is done
`timescale 1ns/100ps

module xbus_arbiter import xbus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  xfer_req_t req0,
  input  xfer_req_t req1,
  output xfer_rsp_t rsp0,
  output xfer_rsp_t rsp1,
  output xfer_req_t bus_req,
  input  xfer_rsp_t bus_rsp
);

  logic prio;    // requester that wins a tie
  logic locked;  // a transfer is in flight
  logic gnt_q;   // owner of the transfer in flight
  logic pick;
  logic gnt;

  // choice for a new transfer
  always_comb begin
    if (req0.valid && req1.valid) begin
      pick = prio;
    end else begin
      pick = req1.valid;  // lone requester, or 0 with nothing valid
    end
  end

  assign gnt     = locked ? gnt_q : pick;
  assign bus_req = gnt ? req1 : req0;

  // serializer is always idle while unlocked, so a forwarded valid is accepted at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio   <= 1'b0;
      locked <= 1'b0;
      gnt_q  <= 1'b0;
    end else if (locked) begin
      if (bus_rsp.done) begin
        locked <= 1'b0;
        prio   <= ~gnt_q;  // loser goes first next time
      end
    end else if (bus_req.valid) begin
      locked <= 1'b1;
      gnt_q  <= pick;
    end
  end

  // done goes only to the owner
  assign rsp0.done  = bus_rsp.done && locked && !gnt_q;
  assign rsp0.rdata = bus_rsp.rdata;
  assign rsp1.done  = bus_rsp.done && locked && gnt_q;
  assign rsp1.rdata = bus_rsp.rdata;

endmodule

// ==== xbus/xbus_serializer.sv ====
// fixed eight-cycle word transfer, no wait states from the device
// top read byte comes straight from xd_in in D3, so rdata is only valid with done
`timescale 1ns/100ps
`include "xbus_config.svh"

module xbus_serializer import xbus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  xfer_req_t req,
  output xfer_rsp_t rsp,
  output pin_byte_t xa,
  output logic      xstb,
  output logic      xwe,
  output pin_byte_t xd_out,
  output logic      xd_oe,
  input  pin_byte_t xd_in
);

  localparam int IDX_W = $clog2(`XBUS_BYTES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`XBUS_BYTES - 1);

  xbus_phase_e phase;
  logic [IDX_W-1:0] idx;      // byte index within the phase
  logic [IDX_W-1:0] idx_nxt;
  logic accept;
  logic last;

  addr_t addr_q;   // latched request
  data_t wdata_q;
  logic [`XBUS_DATA_W-`XBUS_PIN_W-1:0] rd_q;  // read bytes 0..2

  assign accept  = (phase == IDLE) && req.valid;
  assign last    = (idx == LAST_IDX);
  assign idx_nxt = idx + 1'b1;  // wraps back to 0 after the last byte

  // request payload and read assembly
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
    if (phase == DATA && !last) begin
      rd_q[idx*`XBUS_PIN_W +: `XBUS_PIN_W] <= xd_in;  // sampled at end of D cycle
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase  <= IDLE;
      idx    <= '0;
      xa     <= '0;
      xstb   <= 1'b0;
      xwe    <= 1'b0;
      xd_out <= '0;
      xd_oe  <= 1'b0;
    end else begin
      xstb <= 1'b0;  // strobe lasts A0 only
      case (phase)
        IDLE: begin
          if (accept) begin
            phase <= ADDR;
            idx   <= '0;
            xa    <= req.addr[`XBUS_PIN_W-1:0];  // A0 goes out straight from the request
            xstb  <= 1'b1;
            xwe   <= req.write;
          end
        end
        ADDR: begin
          idx <= idx_nxt;
          if (last) begin
            // A3 done, set up D0
            phase  <= DATA;
            xa     <= '0;
            xd_oe  <= xwe;
            xd_out <= xwe ? wdata_q[`XBUS_PIN_W-1:0] : '0;
          end else begin
            xa <= addr_q[idx_nxt*`XBUS_PIN_W +: `XBUS_PIN_W];
          end
        end
        DATA: begin
          idx <= idx_nxt;
          if (last) begin
            phase  <= IDLE;
            xwe    <= 1'b0;
            xd_oe  <= 1'b0;
            xd_out <= '0;
          end else if (xwe) begin
            xd_out <= wdata_q[idx_nxt*`XBUS_PIN_W +: `XBUS_PIN_W];
          end
        end
        default: phase <= IDLE;
      endcase
    end
  end

  // done in D3, serializer back in IDLE on the next edge
  assign rsp.done  = (phase == DATA) && last;
  assign rsp.rdata = {xd_in, rd_q};

endmodule
